// ==== common/lab4_chip_pkg.sv ====
package lab4_chip_pkg;

	// serial setting word of one chip
	localparam int LAB4_REG_WIDTH = 24;

	// chip select, all ones addresses every chip
	localparam int SEL_WIDTH = 5;

	// bit period prescaler
	localparam int PRESCALE_WIDTH = 8;

	// ramp delay and wclk count
	localparam int TIMER_WIDTH = 16;

	////////////////////////////////////////////////////////////
	// register bank to chip side blocks
	////////////////////////////////////////////////////////////

	// word and target of one serial write
	typedef struct packed {
		logic [LAB4_REG_WIDTH-1:0] value;
		logic [SEL_WIDTH-1:0]      select;
	} serial_cmd_t;

	// wilkinson settings
	typedef struct packed {
		logic [TIMER_WIDTH-1:0] delay;
		logic [TIMER_WIDTH-1:0] stop_count;
	} ramp_cfg_t;

endpackage

// ==== common/lab4_bus_pkg.sv ====
package lab4_bus_pkg;

	////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////

	// byte address, word aligned registers
	localparam int ADR_WIDTH = 7;

	localparam logic [ADR_WIDTH-1:0] ADR_CONTROL        = 7'h00;
	localparam logic [ADR_WIDTH-1:0] ADR_SHIFT_PRESCALE = 7'h04;
	localparam logic [ADR_WIDTH-1:0] ADR_RAMP_DELAY     = 7'h0C;
	localparam logic [ADR_WIDTH-1:0] ADR_WCLK_STOP      = 7'h10;
	localparam logic [ADR_WIDTH-1:0] ADR_SERIAL         = 7'h18;
	localparam logic [ADR_WIDTH-1:0] ADR_RAMP_CMD       = 7'h1C;

	////////////////////////////////////////////////////////////
	// wishbone
	////////////////////////////////////////////////////////////

	// master side
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [ADR_WIDTH-1:0] adr;
		logic [31:0]          dat;
	} wb_req_t;

	// slave side, ack is registered
	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} wb_rsp_t;

	// one data word, four layouts picked by address
	typedef union packed {
		// control register
		struct packed {
			logic [15:0] regclear;
			logic [6:0]  rsvd_hi;
			logic        wilk_reset;
			logic [7:0]  rsvd_lo;
		} control;
		// serial write, go doubles as busy on readback
		struct packed {
			logic                                 go;
			logic [30-lab4_chip_pkg::SEL_WIDTH-
				lab4_chip_pkg::LAB4_REG_WIDTH:0]  rsvd;
			logic [lab4_chip_pkg::SEL_WIDTH-1:0]  select;
			logic [lab4_chip_pkg::LAB4_REG_WIDTH-1:0] value;
		} serial;
		// prescale, delay and stop count
		struct packed {
			logic [15:0] rsvd;
			logic [15:0] value;
		} wide;
		// ramp command
		struct packed {
			logic [30:0] rsvd;
			logic        start;
		} cmd;
	} wb_word_u;

endpackage

// ==== src/lab4_regs.sv ====
module lab4_regs #(
	parameter int NUM_REGCLR = 1
) (
	input  logic                                      clk_i,
	input  logic                                      reset_i,

	input  lab4_bus_pkg::wb_req_t                     wb_req_i,
	output lab4_bus_pkg::wb_rsp_t                     wb_rsp_o,

	output logic                                      serial_go_o,
	output lab4_chip_pkg::serial_cmd_t                serial_cmd_o,
	output logic [lab4_chip_pkg::PRESCALE_WIDTH-1:0]  shift_prescale_o,
	input  logic                                      serial_busy_i,

	output logic                                      ramp_start_o,
	output lab4_chip_pkg::ramp_cfg_t                  ramp_cfg_o,
	output logic                                      wilk_reset_o,
	input  logic                                      ramp_busy_i,

	output logic [NUM_REGCLR-1:0]                     regclear_o
);

	localparam logic [lab4_chip_pkg::TIMER_WIDTH-1:0] WCLK_STOP_DEFAULT = 16'd1024;

	lab4_bus_pkg::wb_word_u wr_word;
	lab4_bus_pkg::wb_word_u rd_word;
	logic wr_en;
	logic ack_q;

	// settings
	logic [NUM_REGCLR-1:0] regclear_q;
	logic [lab4_chip_pkg::PRESCALE_WIDTH-1:0] prescale_q;
	lab4_chip_pkg::ramp_cfg_t ramp_cfg_q;
	lab4_chip_pkg::serial_cmd_t serial_cmd_q;

	// one cycle strobes, aligned with ack
	logic serial_go_q;
	logic ramp_start_q;
	logic wilk_reset_q;

	assign wr_word = wb_req_i.dat;
	assign wr_en = wb_req_i.cyc && wb_req_i.stb && wb_req_i.we;

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
			regclear_q <= '0;
			prescale_q <= '0;
			ramp_cfg_q.delay <= '0;
			ramp_cfg_q.stop_count <= WCLK_STOP_DEFAULT;
			serial_cmd_q <= '0;
			serial_go_q <= 1'b0;
			ramp_start_q <= 1'b0;
			wilk_reset_q <= 1'b0;
		end else begin
			ack_q <= wb_req_i.cyc && wb_req_i.stb;
			serial_go_q <= 1'b0;
			ramp_start_q <= 1'b0;
			wilk_reset_q <= 1'b0;
			if (wr_en) begin
				case (wb_req_i.adr)
					lab4_bus_pkg::ADR_CONTROL: begin
						regclear_q <= wr_word.control.regclear[NUM_REGCLR-1:0];
						wilk_reset_q <= wr_word.control.wilk_reset;
					end
					lab4_bus_pkg::ADR_SHIFT_PRESCALE: begin
						prescale_q <= wr_word.wide.value[lab4_chip_pkg::PRESCALE_WIDTH-1:0];
					end
					lab4_bus_pkg::ADR_RAMP_DELAY: begin
						ramp_cfg_q.delay <= wr_word.wide.value;
					end
					lab4_bus_pkg::ADR_WCLK_STOP: begin
						ramp_cfg_q.stop_count <= wr_word.wide.value;
					end
					lab4_bus_pkg::ADR_SERIAL: begin
						serial_cmd_q.value <= wr_word.serial.value;
						serial_cmd_q.select <= wr_word.serial.select;
						// go while a transfer runs is dropped
						serial_go_q <= wr_word.serial.go && !serial_busy_i;
					end
					lab4_bus_pkg::ADR_RAMP_CMD: begin
						ramp_start_q <= wr_word.cmd.start;
					end
					default: begin
					end
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// readback
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_word = '0;
		case (wb_req_i.adr)
			lab4_bus_pkg::ADR_CONTROL: begin
				rd_word.control.regclear[NUM_REGCLR-1:0] = regclear_q;
			end
			lab4_bus_pkg::ADR_SHIFT_PRESCALE: begin
				rd_word.wide.value[lab4_chip_pkg::PRESCALE_WIDTH-1:0] = prescale_q;
			end
			lab4_bus_pkg::ADR_RAMP_DELAY: begin
				rd_word.wide.value = ramp_cfg_q.delay;
			end
			lab4_bus_pkg::ADR_WCLK_STOP: begin
				rd_word.wide.value = ramp_cfg_q.stop_count;
			end
			lab4_bus_pkg::ADR_SERIAL: begin
				rd_word.serial.value = serial_cmd_q.value;
				rd_word.serial.select = serial_cmd_q.select;
				rd_word.serial.go = serial_busy_i;
			end
			lab4_bus_pkg::ADR_RAMP_CMD: begin
				rd_word.cmd.start = ramp_busy_i;
			end
			default: begin
			end
		endcase
	end

	assign wb_rsp_o = '{dat: rd_word, ack: ack_q};

	assign serial_go_o = serial_go_q;
	assign serial_cmd_o = serial_cmd_q;
	assign shift_prescale_o = prescale_q;
	assign ramp_start_o = ramp_start_q;
	assign ramp_cfg_o = ramp_cfg_q;
	assign wilk_reset_o = wilk_reset_q;
	assign regclear_o = regclear_q;

endmodule

// ==== serial/lab4_serial_shifter.sv ====
module lab4_serial_shifter #(
	parameter int NUM_LABS = 4,
	parameter int NUM_SCLK = 2
) (
	input  logic                                      clk_i,
	input  logic                                      reset_i,
	input  logic                                      go_i,
	input  lab4_chip_pkg::serial_cmd_t                cmd_i,
	input  logic [lab4_chip_pkg::PRESCALE_WIDTH-1:0]  prescale_i,
	output logic                                      busy_o,
	output logic [NUM_LABS-1:0]                       sin_o,
	output logic [NUM_SCLK-1:0]                       sclk_o,
	output logic [NUM_LABS-1:0]                       pclk_o
);

	localparam int WORD_W = lab4_chip_pkg::LAB4_REG_WIDTH;
	localparam int SEL_W = lab4_chip_pkg::SEL_WIDTH;
	// two halves per bit, then pclk high and low
	localparam int DATA_HALVES = 2 * WORD_W;
	localparam int HALF_W = $clog2(DATA_HALVES + 2);
	localparam logic [HALF_W-1:0] LAST_BIT_HALF = HALF_W'(DATA_HALVES - 1);
	localparam logic [HALF_W-1:0] PCLK_HALF = HALF_W'(DATA_HALVES);
	localparam logic [HALF_W-1:0] LAST_HALF = HALF_W'(DATA_HALVES + 1);

	logic busy_q;
	logic sin_q;
	logic sclk_q;
	logic pclk_q;
	logic [lab4_chip_pkg::PRESCALE_WIDTH-1:0] presc_cnt;
	logic [HALF_W-1:0] half_cnt;
	logic half_tick;

	// held for the whole transfer
	logic [WORD_W-1:0] shift_q;
	logic [SEL_W-1:0] sel_q;
	logic [lab4_chip_pkg::PRESCALE_WIDTH-1:0] prescale_q;

	logic [NUM_LABS-1:0] chip_en;

	assign half_tick = busy_q && (presc_cnt == prescale_q);

	////////////////////////////////////////////////////////////
	// half period sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q <= 1'b0;
			sin_q <= 1'b0;
			sclk_q <= 1'b0;
			pclk_q <= 1'b0;
			presc_cnt <= '0;
			half_cnt <= '0;
		end else if (!busy_q) begin
			if (go_i) begin
				busy_q <= 1'b1;
				presc_cnt <= '0;
				half_cnt <= '0;
				// msb goes out first
				sin_q <= cmd_i.value[WORD_W-1];
			end
		end else if (!half_tick) begin
			presc_cnt <= presc_cnt + 1'b1;
		end else begin
			presc_cnt <= '0;
			half_cnt <= half_cnt + 1'b1;
			if (half_cnt == LAST_HALF) begin
				busy_q <= 1'b0;
				half_cnt <= '0;
			end else if (half_cnt == PCLK_HALF) begin
				pclk_q <= 1'b0;
			end else if (half_cnt == LAST_BIT_HALF) begin
				sclk_q <= 1'b0;
				sin_q <= 1'b0;
				pclk_q <= 1'b1;
			end else if (half_cnt[0]) begin
				// end of a high half, next bit
				sclk_q <= 1'b0;
				sin_q <= shift_q[WORD_W-2];
			end else begin
				sclk_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!busy_q && go_i) begin
			shift_q <= cmd_i.value;
			sel_q <= cmd_i.select;
			prescale_q <= prescale_i;
		end else if (half_tick && half_cnt[0] && half_cnt < LAST_BIT_HALF) begin
			shift_q <= shift_q << 1;
		end
	end

	////////////////////////////////////////////////////////////
	// chip fan out
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < NUM_LABS; i++) begin
			chip_en[i] = (&sel_q) || (sel_q == SEL_W'(i));
		end
	end

	assign sin_o = {NUM_LABS{sin_q}} & chip_en;
	assign pclk_o = {NUM_LABS{pclk_q}} & chip_en;
	assign sclk_o = {NUM_SCLK{sclk_q}};
	assign busy_o = busy_q;

endmodule

// ==== ramp/lab4_wilkinson_ramp.sv ====
module lab4_wilkinson_ramp #(
	parameter int NUM_RAMP = 2
) (
	input  logic                      clk_i,
	input  logic                      reset_i,
	input  logic                      start_i,
	input  logic                      abort_i,
	input  lab4_chip_pkg::ramp_cfg_t  cfg_i,
	output logic                      busy_o,
	output logic [NUM_RAMP-1:0]       ramp_o,
	output logic                      wclk_o
);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_DELAY = 2'd1;
	localparam logic [1:0] ST_RUN   = 2'd2;

	logic [1:0] state_q;
	logic wclk_q;
	logic [lab4_chip_pkg::TIMER_WIDTH-1:0] delay_cnt;
	logic [lab4_chip_pkg::TIMER_WIDTH-1:0] edge_cnt;

	// settings taken at start
	lab4_chip_pkg::ramp_cfg_t cfg_q;

	always_ff @(posedge clk_i) begin
		if (reset_i || abort_i) begin
			state_q <= ST_IDLE;
			wclk_q <= 1'b0;
			delay_cnt <= '0;
			edge_cnt <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (start_i) begin
						if (cfg_i.delay == '0) begin
							// no delay, first wclk edge with ramp
							state_q <= ST_RUN;
							wclk_q <= 1'b1;
							edge_cnt <= 16'd1;
						end else begin
							state_q <= ST_DELAY;
							delay_cnt <= 16'd1;
						end
					end
				end
				ST_DELAY: begin
					if (delay_cnt == cfg_q.delay) begin
						state_q <= ST_RUN;
						wclk_q <= 1'b1;
						edge_cnt <= 16'd1;
					end else begin
						delay_cnt <= delay_cnt + 1'b1;
					end
				end
				ST_RUN: begin
					if (wclk_q) begin
						wclk_q <= 1'b0;
					end else if (edge_cnt >= cfg_q.stop_count) begin
						// last falling edge is done
						state_q <= ST_IDLE;
					end else begin
						wclk_q <= 1'b1;
						edge_cnt <= edge_cnt + 1'b1;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == ST_IDLE && start_i) begin
			cfg_q <= cfg_i;
		end
	end

	// ramp held for the whole sequence
	assign busy_o = (state_q != ST_IDLE);
	assign ramp_o = {NUM_RAMP{busy_o}};
	assign wclk_o = wclk_q;

endmodule

// ==== src/lab4_controller.sv ====
module lab4_controller #(
	parameter int NUM_LABS   = 4,
	parameter int NUM_SCLK   = 2,
	parameter int NUM_REGCLR = 1,
	parameter int NUM_RAMP   = 2
) (
	input  logic                   clk_i,
	input  logic                   reset_i,

	input  lab4_bus_pkg::wb_req_t  wb_req_i,
	output lab4_bus_pkg::wb_rsp_t  wb_rsp_o,

	output logic [NUM_LABS-1:0]    sin_o,
	output logic [NUM_SCLK-1:0]    sclk_o,
	output logic [NUM_LABS-1:0]    pclk_o,
	output logic [NUM_RAMP-1:0]    ramp_o,
	output logic                   wclk_o,
	output logic [NUM_REGCLR-1:0]  regclr_o
);

	// serial path
	logic serial_go;
	logic serial_busy;
	lab4_chip_pkg::serial_cmd_t serial_cmd;
	logic [lab4_chip_pkg::PRESCALE_WIDTH-1:0] shift_prescale;

	// ramp path
	logic ramp_start;
	logic ramp_busy;
	logic wilk_reset;
	lab4_chip_pkg::ramp_cfg_t ramp_cfg;

	lab4_regs #(
		.NUM_REGCLR(NUM_REGCLR)
	) lab4_regs_inst (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.wb_req_i(wb_req_i),
		.wb_rsp_o(wb_rsp_o),
		.serial_go_o(serial_go),
		.serial_cmd_o(serial_cmd),
		.shift_prescale_o(shift_prescale),
		.serial_busy_i(serial_busy),
		.ramp_start_o(ramp_start),
		.ramp_cfg_o(ramp_cfg),
		.wilk_reset_o(wilk_reset),
		.ramp_busy_i(ramp_busy),
		.regclear_o(regclr_o)
	);

	lab4_serial_shifter #(
		.NUM_LABS(NUM_LABS),
		.NUM_SCLK(NUM_SCLK)
	) lab4_serial_shifter_inst (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.go_i(serial_go),
		.cmd_i(serial_cmd),
		.prescale_i(shift_prescale),
		.busy_o(serial_busy),
		.sin_o(sin_o),
		.sclk_o(sclk_o),
		.pclk_o(pclk_o)
	);

	lab4_wilkinson_ramp #(
		.NUM_RAMP(NUM_RAMP)
	) lab4_wilkinson_ramp_inst (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.start_i(ramp_start),
		.abort_i(wilk_reset),
		.cfg_i(ramp_cfg),
		.busy_o(ramp_busy),
		.ramp_o(ramp_o),
		.wclk_o(wclk_o)
	);

endmodule

// ==== tests/lab4_controller_properties.sv ====
module lab4_controller_properties #(
	parameter int NUM_LABS = 4,
	parameter int NUM_SCLK = 2,
	parameter int NUM_RAMP = 2
) (
	input  logic                   clk_i,
	input  logic                   reset_i,
	input  lab4_bus_pkg::wb_rsp_t  wb_rsp_i,
	input  logic [NUM_SCLK-1:0]    sclk_i,
	input  logic [NUM_LABS-1:0]    pclk_i,
	input  logic [NUM_RAMP-1:0]    ramp_i,
	input  logic                   wclk_i
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// master drops stb as soon as it sees ack
	ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
		wb_rsp_i.ack |=> !wb_rsp_i.ack)
		else begin
			$error("ack stayed high for two cycles");
			fail_count++;
		end

	// load pulse only after the last bit
	pclk_sclk_apart: assert property (@(posedge clk_i) disable iff (reset_i)
		!((|pclk_i) && (|sclk_i)))
		else begin
			$error("pclk and sclk high together");
			fail_count++;
		end

	// an abort may drop wclk in the same cycle as ramp
	wclk_in_ramp: assert property (@(posedge clk_i) disable iff (reset_i)
		$changed(wclk_i) |-> (ramp_i[0] || $past(ramp_i[0])))
		else begin
			$error("wclk toggled while ramp was low");
			fail_count++;
		end

endmodule

bind lab4_controller lab4_controller_properties #(
	.NUM_LABS(NUM_LABS),
	.NUM_SCLK(NUM_SCLK),
	.NUM_RAMP(NUM_RAMP)
) lab4_controller_properties_inst (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.wb_rsp_i(wb_rsp_o),
	.sclk_i(sclk_o),
	.pclk_i(pclk_o),
	.ramp_i(ramp_o),
	.wclk_i(wclk_o)
);

// ==== tests/lab4_controller_tb.sv ====
module lab4_controller_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_LABS = 4;
	localparam int NUM_SCLK = 2;
	localparam int NUM_REGCLR = 1;
	localparam int NUM_RAMP = 2;
	localparam int ACK_TIMEOUT = 16;

	logic clk_i;
	logic reset_i;
	lab4_bus_pkg::wb_req_t wb_req;
	lab4_bus_pkg::wb_rsp_t wb_rsp;
	logic [NUM_LABS-1:0] sin;
	logic [NUM_SCLK-1:0] sclk;
	logic [NUM_LABS-1:0] pclk;
	logic [NUM_RAMP-1:0] ramp;
	logic wclk;
	logic [NUM_REGCLR-1:0] regclr;

	integer seed;
	int mismatch_count;
	int timeout_count;
	int waited;
	logic [31:0] rdata;
	logic [31:0] wdata;
	logic [6:0] addr;

	// register shadow
	logic [NUM_REGCLR-1:0] exp_regclear;
	logic [7:0] exp_prescale;
	logic [15:0] exp_delay;
	logic [15:0] exp_stop;
	logic [23:0] exp_value;
	logic [4:0] exp_select;

	lab4_controller #(
		.NUM_LABS(NUM_LABS),
		.NUM_SCLK(NUM_SCLK),
		.NUM_REGCLR(NUM_REGCLR),
		.NUM_RAMP(NUM_RAMP)
	) lab4_controller_inst (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.wb_req_i(wb_req),
		.wb_rsp_o(wb_rsp),
		.sin_o(sin),
		.sclk_o(sclk),
		.pclk_o(pclk),
		.ramp_o(ramp),
		.wclk_o(wclk),
		.regclr_o(regclr)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#20 clk_i = ~clk_i;
		end
	end

	////////////////////////////////////////////////////////////
	// checks and bus access
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error at %0d ns: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual);
			mismatch_count++;
		end
	endtask

	// readback word built from the shadow, busy bits idle
	function automatic logic [31:0] expected_read(input logic [6:0] address);
		logic [31:0] word;
		word = '0;
		case (address)
			lab4_bus_pkg::ADR_CONTROL: word[16 +: NUM_REGCLR] = exp_regclear;
			lab4_bus_pkg::ADR_SHIFT_PRESCALE: word[7:0] = exp_prescale;
			lab4_bus_pkg::ADR_RAMP_DELAY: word[15:0] = exp_delay;
			lab4_bus_pkg::ADR_WCLK_STOP: word[15:0] = exp_stop;
			lab4_bus_pkg::ADR_SERIAL: word[28:0] = {exp_select, exp_value};
			default: word = '0;
		endcase
		return word;
	endfunction

	// starts and ends on a falling edge, one idle cycle ahead of the request
	task automatic bus_access(input logic we, input logic [6:0] address,
		input logic [31:0] data, output logic [31:0] rd);
		int cycles;
		cycles = 0;
		rd = '0;
		@(negedge clk_i);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: address, dat: data};
		do begin
			@(negedge clk_i);
			cycles++;
		end while (!wb_rsp.ack && cycles < ACK_TIMEOUT);
		if (wb_rsp.ack) begin
			rd = wb_rsp.dat;
		end else begin
			$display("timeout: no ack from address 0x%02h", address);
			timeout_count++;
		end
		wb_req = '0;
	endtask

	task automatic check_reg(input logic [6:0] address, input string name);
		logic [31:0] rd;
		bus_access(1'b0, address, '0, rd);
		check_value(name, expected_read(address), rd);
	endtask

	task automatic wait_serial_idle();
		logic [31:0] rd;
		int polls;
		polls = 0;
		rd = 32'h8000_0000;
		while (rd[31] && polls < 20) begin
			bus_access(1'b0, lab4_bus_pkg::ADR_SERIAL, '0, rd);
			polls++;
		end
		if (rd[31]) begin
			$display("timeout: serial busy bit never returned to zero");
			timeout_count++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// serial and ramp sequences
	////////////////////////////////////////////////////////////

	task automatic serial_transfer(input logic [4:0] select, input logic [23:0] value,
		input logic [7:0] prescale, input bit second_go);
		logic [NUM_LABS-1:0][23:0] captured;
		int pclk_pulses [NUM_LABS];
		logic [NUM_LABS-1:0] chip_mask;
		logic [NUM_LABS-1:0] stray;
		logic [NUM_LABS-1:0] pclk_prev;
		logic sclk_prev;
		logic [31:0] rd;
		int bits;
		int cycles;
		bit done;
		bit sclk_split;
		captured = '0;
		stray = '0;
		bits = 0;
		cycles = 0;
		done = 1'b0;
		sclk_split = 1'b0;
		for (int i = 0; i < NUM_LABS; i++) begin
			pclk_pulses[i] = 0;
			chip_mask[i] = (select == 5'h1f) || (select == i);
		end
		bus_access(1'b1, lab4_bus_pkg::ADR_SHIFT_PRESCALE, {24'h0, prescale}, rd);
		exp_prescale = prescale;
		bus_access(1'b1, lab4_bus_pkg::ADR_SERIAL, {3'b100, select, value}, rd);
		exp_value = value;
		exp_select = select;
		sclk_prev = sclk[0];
		pclk_prev = pclk;
		fork
			while (!done && cycles < 50 * (prescale + 1) + 40) begin
				@(negedge clk_i);
				cycles++;
				// sin is stable through the high half
				if (sclk[0] && !sclk_prev) begin
					bits++;
					for (int i = 0; i < NUM_LABS; i++) begin
						captured[i] = {captured[i][22:0], sin[i]};
					end
				end
				for (int i = 0; i < NUM_LABS; i++) begin
					if (pclk[i] && !pclk_prev[i]) begin
						pclk_pulses[i]++;
					end
				end
				stray |= (sin | pclk) & ~chip_mask;
				// every sclk output carries the same clock
				sclk_split |= (sclk != {NUM_SCLK{sclk[0]}});
				done = (|pclk_prev) && !(|pclk);
				sclk_prev = sclk[0];
				pclk_prev = pclk;
			end
			if (second_go) begin
				bus_access(1'b0, lab4_bus_pkg::ADR_SERIAL, '0, rd);
				check_value("serial busy bit", 32'd1, {31'd0, rd[31]});
				exp_value = $random(seed);
				bus_access(1'b1, lab4_bus_pkg::ADR_SERIAL, {3'b100, select, exp_value}, rd);
			end
		join
		if (!done) begin
			$display("timeout: serial transfer to select %0d gave no load pulse", select);
			timeout_count++;
		end
		wait_serial_idle();
		check_value("sclk_o rising edges", 32'd24, bits);
		check_value("sclk_o copy mismatch", 32'd0, sclk_split);
		for (int i = 0; i < NUM_LABS; i++) begin
			if (chip_mask[i]) begin
				check_value($sformatf("sin_o[%0d] word", i), value, captured[i]);
				check_value($sformatf("pclk_o[%0d] pulses", i), 32'd1, pclk_pulses[i]);
			end else begin
				check_value($sformatf("sin_o/pclk_o[%0d] activity", i), 32'd0, stray[i]);
			end
		end
		check_reg(lab4_bus_pkg::ADR_SERIAL, "serial register");
		if (second_go) begin
			bits = 0;
			sclk_prev = sclk[0];
			repeat (4 * (prescale + 1) + 8) begin
				@(negedge clk_i);
				if (sclk[0] && !sclk_prev) begin
					bits++;
				end
				sclk_prev = sclk[0];
			end
			check_value("sclk_o edges after ignored go", 32'd0, bits);
		end
	endtask

	task automatic ramp_sequence(input logic [15:0] delay, input logic [15:0] count);
		logic [31:0] rd;
		logic ramp_prev;
		logic wclk_prev;
		bit wclk_started;
		bit done;
		bit ramp_split;
		int delay_seen;
		int wclk_edges;
		int cycles;
		delay_seen = 0;
		wclk_edges = 0;
		cycles = 0;
		wclk_started = 1'b0;
		done = 1'b0;
		ramp_split = 1'b0;
		bus_access(1'b1, lab4_bus_pkg::ADR_RAMP_DELAY, {16'h0, delay}, rd);
		exp_delay = delay;
		bus_access(1'b1, lab4_bus_pkg::ADR_WCLK_STOP, {16'h0, count}, rd);
		exp_stop = count;
		bus_access(1'b1, lab4_bus_pkg::ADR_RAMP_CMD, 32'h1, rd);
		ramp_prev = ramp[0];
		wclk_prev = wclk;
		fork
			while (!done && cycles < delay + 2 * count + 20) begin
				@(negedge clk_i);
				cycles++;
				if (ramp[0] && wclk && !wclk_prev) begin
					wclk_edges++;
					wclk_started = 1'b1;
				end else if (ramp[0] && !wclk_started) begin
					delay_seen++;
				end
				// all ramp outputs move together
				ramp_split |= (ramp != {NUM_RAMP{ramp[0]}});
				done = ramp_prev && !ramp[0];
				ramp_prev = ramp[0];
				wclk_prev = wclk;
			end
			begin
				bus_access(1'b0, lab4_bus_pkg::ADR_RAMP_CMD, '0, rd);
				check_value("ramp busy bit", 32'd1, rd);
			end
		join
		if (!done) begin
			$display("timeout: ramp output never fell after start");
			timeout_count++;
		end
		check_value("cycles from ramp_o to wclk_o", delay, delay_seen);
		check_value("wclk_o rising edges", count, wclk_edges);
		check_value("ramp_o copy mismatch", 32'd0, ramp_split);
		check_reg(lab4_bus_pkg::ADR_RAMP_CMD, "ramp busy bit after ramp");
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		seed = 32'h8eba1907;
		mismatch_count = 0;
		timeout_count = 0;
		reset_i = 1'b1;
		wb_req = '0;
		exp_regclear = '0;
		exp_prescale = '0;
		exp_delay = '0;
		exp_stop = 16'd1024;
		exp_value = '0;
		exp_select = '0;
		repeat (4) @(negedge clk_i);
		reset_i = 1'b0;

		check_value("{sin_o,sclk_o,pclk_o,ramp_o,wclk_o,regclr_o}", 32'd0,
			{sin, sclk, pclk, ramp, wclk, regclr});
		for (int a = 0; a < 8; a++) begin
			check_reg(7'(a * 4), $sformatf("reset value at 0x%02h", a * 4));
		end

		// random word addresses, unmapped ones read zero
		repeat (10) begin
			addr = 7'($random(seed)) & 7'h7c;
			check_reg(addr, $sformatf("read of 0x%02h", addr));
		end

		repeat (16) begin
			wdata = $random(seed);
			case ($unsigned($random(seed)) % 4)
				0: begin
					addr = lab4_bus_pkg::ADR_CONTROL;
					exp_regclear = wdata[16 +: NUM_REGCLR];
				end
				1: begin
					addr = lab4_bus_pkg::ADR_SHIFT_PRESCALE;
					exp_prescale = wdata[7:0];
				end
				2: begin
					addr = lab4_bus_pkg::ADR_RAMP_DELAY;
					exp_delay = wdata[15:0];
				end
				default: begin
					addr = lab4_bus_pkg::ADR_WCLK_STOP;
					exp_stop = wdata[15:0];
				end
			endcase
			bus_access(1'b1, addr, wdata, rdata);
			check_value("regclr_o", exp_regclear, regclr);
			check_reg(addr, $sformatf("readback of 0x%02h", addr));
		end

		repeat (4) begin
			serial_transfer(5'($unsigned($random(seed)) % 4), 24'($random(seed)),
				8'($unsigned($random(seed)) % 4), 1'b0);
		end
		serial_transfer(5'h1f, 24'($random(seed)), 8'($unsigned($random(seed)) % 4), 1'b1);

		repeat (3) begin
			ramp_sequence(16'($unsigned($random(seed)) % 8 + 2),
				16'($unsigned($random(seed)) % 8 + 2));
		end

		// wilkinson reset while wclk runs
		bus_access(1'b1, lab4_bus_pkg::ADR_RAMP_DELAY, 32'd2, rdata);
		exp_delay = 16'd2;
		bus_access(1'b1, lab4_bus_pkg::ADR_WCLK_STOP, 32'd200, rdata);
		exp_stop = 16'd200;
		bus_access(1'b1, lab4_bus_pkg::ADR_RAMP_CMD, 32'h1, rdata);
		waited = 0;
		while (!wclk && waited < 16) begin
			@(negedge clk_i);
			waited++;
		end
		if (!wclk) begin
			$display("timeout: wclk output never started before the abort");
			timeout_count++;
		end
		wdata = $random(seed) | 32'h100;
		exp_regclear = wdata[16 +: NUM_REGCLR];
		bus_access(1'b1, lab4_bus_pkg::ADR_CONTROL, wdata, rdata);
		waited = 0;
		while (ramp[0] && waited < 2) begin
			@(negedge clk_i);
			waited++;
		end
		check_value("ramp_o after wilkinson reset", 32'd0, ramp);
		check_value("wclk_o after wilkinson reset", 32'd0, wclk);
		check_value("regclr_o", exp_regclear, regclr);
		check_reg(lab4_bus_pkg::ADR_RAMP_CMD, "ramp busy bit after abort");
		check_reg(lab4_bus_pkg::ADR_CONTROL, "control readback");

		$display("errors: %0d value mismatches, %0d timeouts, %0d assertion failures",
			mismatch_count, timeout_count,
			lab4_controller_inst.lab4_controller_properties_inst.fail_count);
		if (mismatch_count == 0 && timeout_count == 0 &&
			lab4_controller_inst.lab4_controller_properties_inst.fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
common/lab4_chip_pkg.sv
common/lab4_bus_pkg.sv
src/lab4_regs.sv
serial/lab4_serial_shifter.sv
ramp/lab4_wilkinson_ramp.sv
src/lab4_controller.sv
tests/lab4_controller_properties.sv
tests/lab4_controller_tb.sv
